/* testbench/core_stim.txt */
// kind_word_gap_reg_data, kind 1 is an instruction and kind 2 a level change
// word holds the instruction or the level, gap is idle cycles before it, reg and data the commit
1_6105_02_1_0005
1_620C_00_2_000C
1_0312_00_3_0011
1_1431_00_4_000C
1_7534_00_5_0110
1_2653_01_6_0010
1_3751_00_7_0115
1_4873_00_8_0104
1_0012_00_0_0000
1_0901_00_9_0005
1_1A01_00_A_FFFB
1_5BA7_00_B_FA97
1_0CB1_00_C_FA9C
1_F000_00_0_0000
1_4DCB_00_D_000B
1_5E55_03_E_2100
1_F123_00_0_0000
1_F000_00_0_0000
1_3FE1_00_F_2105
2_0003_02_0_0000
1_0134_00_1_0018
1_1271_00_2_00F8
1_632F_00_3_0100
1_5479_00_4_0568
1_267D_00_6_0001
1_361D_00_6_001B
1_488D_00_8_010F
1_7AD1_00_A_0016
2_0000_01_0_0000
1_0BD1_00_B_0023
1_5CDD_00_C_0079

/* coreSlice.f */
hw/CoreTypes.sv
hw/RegisterFile.sv
hw/DecodeStage.sv
hw/ExecutionStage.sv
hw/CommitStage.sv
hw/Core.sv
testbench/CoreTb_assert.sv
testbench/CoreTb.sv

/* run.sh */
#!/bin/sh
# Build the core slice testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module CoreTb -f coreSlice.f -o CoreTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/CoreTbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "Run passed"
    exit 0
else
    echo "Run failed, pass message not found in $LOG"
    exit 1
fi

/* testbench/CoreTb.sv */
// Core slice testbench
// Drives instructions from the stimulus file under credit flow control,
// models the ISA and checks every commit in order
`timescale 1ns/1ps

module CoreTb;
    import CoreTypes::*;

    localparam int STIM_DEPTH = 64;
    localparam int CREDIT_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 200;

    logic clk;
    logic rst;
    logic instValid;
    InstWord instWord;
    logic axLevelEn;
    logic [AX_LEVEL_WIDTH-1:0] axLevelData;
    logic creditReturn;
    logic commitValid;
    RegNumPath commitReg;
    DataPath commitData;

    // Kind, word or level, gap, expected register, expected data
    logic [47:0] stimMem [STIM_DEPTH];
    DataPath modelRegs [REG_NUM];
    logic [AX_LEVEL_WIDTH-1:0] modelLevel;
    RegNumPath expRegQ [$];
    DataPath expDataQ [$];
    int credits;
    logic firstSent;

    Core i_Core (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .instWord(instWord),
        .axLevelEn(axLevelEn),
        .axLevelData(axLevelData),
        .creditReturn(creditReturn),
        .commitValid(commitValid),
        .commitReg(commitReg),
        .commitData(commitData)
    );

    bind Core CoreTb_assert coreChecks (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .creditReturn(creditReturn),
        .resultValid(resultValid),
        .commitValid(commitValid),
        .execBusy(execBusy)
    );

    always #50 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    function automatic DataPath clearLowBits(DataPath value, logic [AX_LEVEL_WIDTH-1:0] level);
        DataPath mask;
        mask = '1;
        mask = mask << level;
        return value & mask;
    endfunction

    // Arithmetic ops honor the approximation level
    function automatic DataPath modelResult(InstWord word);
        DataPath a;
        DataPath b;
        DataPath imm;
        DataPath result;
        a = modelRegs[word.rType.rs1];
        b = modelRegs[word.rType.rs2];
        imm = DataPath'(word.iType.imm);
        case (word.rType.opcode)
            ADD: result = clearLowBits(a + b, modelLevel);
            SUB: result = clearLowBits(a - b, modelLevel);
            AND: result = a & b;
            OR: result = a | b;
            XOR: result = a ^ b;
            MUL: result = clearLowBits(a * b, modelLevel);
            ADDI: result = clearLowBits(a + imm, modelLevel);
            SLLI: result = a << imm;
            default: result = '0;
        endcase
        return result;
    endfunction

    task automatic waitCredit();
        int waited;
        waited = 0;
        while (credits == 0) begin
            stepCycle();
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
                failRun("Timed out waiting for an instruction credit");
            end
        end
    endtask

    // Queue empty and all credits home means nothing is in flight
    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expRegQ.size() != 0 || credits != INST_QUEUE_DEPTH) begin
            stepCycle();
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                failRun("Timed out waiting for the pipeline to drain");
            end
        end
    endtask

    task automatic sendInst(input InstWord word, input RegNumPath fileReg, input DataPath fileData);
        DataPath modelData;
        RegNumPath rd;
        waitCredit();
        if (word.rType.opcode != NOP) begin
            modelData = modelResult(word);
            rd = word.rType.rd;
            if (rd != '0) begin
                modelRegs[rd] = modelData;
            end else begin
                modelData = '0;
            end
            assert (rd == fileReg) else begin
                failRun($sformatf("FAILED stimulus commitReg file %h model %h", fileReg, rd));
            end
            assert (modelData == fileData) else begin
                failRun($sformatf("FAILED stimulus commitData file %h model %h",
                    fileData, modelData));
            end
            expRegQ.push_back(rd);
            expDataQ.push_back(modelData);
        end
        instValid = 1'b1;
        instWord = word;
        firstSent = 1'b1;
        stepCycle();
        instValid = 1'b0;
    endtask

    task automatic setLevel(input logic [AX_LEVEL_WIDTH-1:0] level);
        waitDrain();
        modelLevel = level;
        axLevelEn = 1'b1;
        axLevelData = level;
        stepCycle();
        axLevelEn = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            credits = INST_QUEUE_DEPTH;
        end else begin
            credits = credits - int'(instValid) + int'(creditReturn);
            assert (credits >= 0 && credits <= INST_QUEUE_DEPTH) else begin
                failRun("Credit count left its range, a credit was lost or returned twice");
            end
        end
    end

    always @(negedge clk) begin
        RegNumPath expReg;
        DataPath expData;
        if (!rst && !firstSent) begin
            assert (!commitValid && !creditReturn) else begin
                failRun("Commit or credit activity before the first instruction was sent");
            end
        end
        if (!rst && commitValid) begin
            assert (expRegQ.size() != 0) else begin
                failRun("Commit seen with no instruction left to commit");
            end
            expReg = expRegQ.pop_front();
            expData = expDataQ.pop_front();
            assert (commitReg == expReg) else begin
                failRun($sformatf("FAILED commitReg expected %h actual %h", expReg, commitReg));
            end
            assert (commitData == expData) else begin
                failRun($sformatf("FAILED commitData expected %h actual %h", expData, commitData));
            end
        end
    end

    initial begin
        logic [47:0] entry;
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        axLevelEn = 1'b0;
        axLevelData = '0;
        firstSent = 1'b0;
        modelLevel = '0;
        for (int i = 0; i < REG_NUM; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stimMem[i] = '0;
        end
        void'($urandom(37));
        $readmemh("testbench/core_stim.txt", stimMem);

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // Nothing may commit or return during the idle stretch
        repeat (3) stepCycle();

        for (int idx = 0; idx < STIM_DEPTH; idx++) begin
            entry = stimMem[idx];
            if (entry[47:44] == 4'h0) begin
                break;
            end
            gap = int'(entry[27:20]);
            repeat (gap) stepCycle();
            if ($urandom % 4 == 0) begin
                stepCycle();
            end
            if (entry[47:44] == 4'h2) begin
                setLevel(entry[31:28]);
            end else if (entry[47:44] == 4'h1) begin
                sendInst(entry[43:28], entry[19:16], entry[15:0]);
            end else begin
                failRun("Unknown entry kind in the stimulus file");
            end
        end

        waitDrain();
        // Quiet period catches stray commits from dropped NOPs
        repeat (10) stepCycle();
        if (expRegQ.size() == 0 && credits == INST_QUEUE_DEPTH) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            failRun($sformatf("FAILED credits expected %h actual %h", INST_QUEUE_DEPTH, credits));
        end
    end

endmodule : CoreTb

/* testbench/CoreTb_assert.sv */
// Core slice protocol checks
// Credit bounds, commit timing and multiplier busy length
`timescale 1ns/1ps

module CoreTb_assert (
    input logic clk,
    input logic rst,
    input logic instValid,
    input logic creditReturn,
    input logic resultValid,
    input logic commitValid,
    input logic execBusy
);
    import CoreTypes::*;

    int outstanding;
    int busyRun;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
            busyRun <= 0;
        end else begin
            outstanding <= outstanding + int'(instValid) - int'(creditReturn);
            busyRun <= execBusy ? busyRun + 1 : 0;
        end
    end

    creditRange: assert property (@(posedge clk) disable iff (rst)
        outstanding >= 0 && outstanding <= INST_QUEUE_DEPTH)
        else $error("Outstanding credit count out of range: %0d", outstanding);

    commitAfterResult: assert property (@(posedge clk) disable iff (rst)
        resultValid |=> commitValid)
        else $error("commitValid missing one cycle after resultValid");

    commitHasResult: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> $past(resultValid))
        else $error("commitValid without a result in the previous cycle");

    busyLength: assert property (@(posedge clk) disable iff (rst)
        !(execBusy && busyRun >= MUL_CYCLES))
        else $error("execBusy held longer than the multiplier needs");

endmodule : CoreTb_assert

/* hw/Core.sv */
// Core slice top level
// Wires decode, execution and commit stages around the register file
`timescale 1ns/1ps

module Core (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    input  CoreTypes::InstWord instWord,
    input  logic axLevelEn,
    input  logic [CoreTypes::AX_LEVEL_WIDTH-1:0] axLevelData,
    output logic creditReturn,
    output logic commitValid,
    output CoreTypes::RegNumPath commitReg,
    output CoreTypes::DataPath commitData
);
    import CoreTypes::*;

    // Decode to execution
    logic issueValid;
    OpCode issueOp;
    RegNumPath issueRd;
    RegNumPath issueRs1;
    RegNumPath issueRs2;
    RegNumPath issueImm;
    logic issueUsesImm;
    logic execBusy;

    // Register file ports
    RegNumPath readAddrA;
    RegNumPath readAddrB;
    DataPath readDataA;
    DataPath readDataB;
    logic writeEnable;
    RegNumPath writeAddr;
    DataPath writeData;

    // Execution to commit
    logic resultValid;
    RegNumPath resultReg;
    DataPath resultData;

    DecodeStage idStage (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .instWord(instWord),
        .execBusy(execBusy),
        .creditReturn(creditReturn),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueRd(issueRd),
        .issueRs1(issueRs1),
        .issueRs2(issueRs2),
        .issueImm(issueImm),
        .issueUsesImm(issueUsesImm)
    );

    ExecutionStage exStage (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueRd(issueRd),
        .issueRs1(issueRs1),
        .issueRs2(issueRs2),
        .issueImm(issueImm),
        .issueUsesImm(issueUsesImm),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .axLevelEn(axLevelEn),
        .axLevelData(axLevelData),
        .execBusy(execBusy),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .resultValid(resultValid),
        .resultReg(resultReg),
        .resultData(resultData)
    );

    CommitStage cmStage (
        .clk(clk),
        .rst(rst),
        .resultValid(resultValid),
        .resultReg(resultReg),
        .resultData(resultData),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .commitValid(commitValid),
        .commitReg(commitReg),
        .commitData(commitData)
    );

    RegisterFile registerFile (
        .clk(clk),
        .rst(rst),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

endmodule : Core

/* hw/CommitStage.sv */
// Commit stage
// Turns each execution result into a commit and a register file write
`timescale 1ns/1ps

module CommitStage (
    input  logic clk,
    input  logic rst,
    input  logic resultValid,
    input  CoreTypes::RegNumPath resultReg,
    input  CoreTypes::DataPath resultData,
    output logic writeEnable,
    output CoreTypes::RegNumPath writeAddr,
    output CoreTypes::DataPath writeData,
    output logic commitValid,
    output CoreTypes::RegNumPath commitReg,
    output CoreTypes::DataPath commitData
);

    // Write lands on the same edge that raises commitValid
    assign writeEnable = resultValid && (resultReg != '0);
    assign writeAddr = resultReg;
    assign writeData = resultData;

    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid <= 1'b0;
        end else begin
            commitValid <= resultValid;
        end
    end

    // Register 0 commits but shows its architectural value
    always_ff @(posedge clk) begin
        if (resultValid) begin
            commitReg <= resultReg;
            commitData <= (resultReg == '0) ? '0 : resultData;
        end
    end

endmodule : CommitStage

/* hw/ExecutionStage.sv */
// Execution stage
// Operand bypass, single-cycle ALU, shift-add multiplier and
// approximation truncation of the arithmetic results
`timescale 1ns/1ps

module ExecutionStage (
    input  logic clk,
    input  logic rst,
    input  logic issueValid,
    input  CoreTypes::OpCode issueOp,
    input  CoreTypes::RegNumPath issueRd,
    input  CoreTypes::RegNumPath issueRs1,
    input  CoreTypes::RegNumPath issueRs2,
    input  CoreTypes::RegNumPath issueImm,
    input  logic issueUsesImm,
    input  CoreTypes::DataPath readDataA,
    input  CoreTypes::DataPath readDataB,
    input  logic axLevelEn,
    input  logic [CoreTypes::AX_LEVEL_WIDTH-1:0] axLevelData,
    output logic execBusy,
    output CoreTypes::RegNumPath readAddrA,
    output CoreTypes::RegNumPath readAddrB,
    output logic resultValid,
    output CoreTypes::RegNumPath resultReg,
    output CoreTypes::DataPath resultData
);
    import CoreTypes::*;

    logic [AX_LEVEL_WIDTH-1:0] axLevel;
    logic [AX_LEVEL_WIDTH-1:0] mulLevel;
    DataPath opA;
    DataPath opB;
    DataPath aluB;
    DataPath aluOut;
    logic aluTruncate;
    logic mulStart;
    logic mulActive;
    logic mulLast;
    logic [MUL_COUNT_WIDTH-1:0] mulCount;
    RegNumPath mulRd;
    DataPath mulAcc;
    DataPath mulCand;
    DataPath mulPlier;
    DataPath stepAcc;
    DataPath stepCand;
    DataPath stepPlier;
    DataPath stepSum;

    function automatic DataPath truncateLow(DataPath value, logic [AX_LEVEL_WIDTH-1:0] level);
        return value & (~DataPath'(0) << level);
    endfunction

    function automatic DataPath partialProduct(DataPath cand, logic [MUL_STEP_BITS-1:0] digit);
        DataPath sum;
        sum = '0;
        for (int i = 0; i < MUL_STEP_BITS; i++) begin
            if (digit[i]) begin
                sum = sum + (cand << i);
            end
        end
        return sum;
    endfunction

    assign readAddrA = issueRs1;
    assign readAddrB = issueRs2;

    // Busy from the issue cycle of a MUL until its last step
    assign mulStart = issueValid && (issueOp == MUL);
    assign mulLast = mulActive && (mulCount == MUL_COUNT_WIDTH'(1));
    assign execBusy = mulStart || mulActive;

    // Last result is not in the register file yet
    assign opA = (resultValid && resultReg == issueRs1 && issueRs1 != '0) ? resultData : readDataA;
    assign opB = (resultValid && resultReg == issueRs2 && issueRs2 != '0) ? resultData : readDataB;
    assign aluB = issueUsesImm ? DataPath'(issueImm) : opB;

    always_comb begin
        aluOut = '0;
        aluTruncate = 1'b0;
        case (issueOp)
            ADD, ADDI: begin
                aluOut = opA + aluB;
                aluTruncate = 1'b1;
            end
            SUB: begin
                aluOut = opA - aluB;
                aluTruncate = 1'b1;
            end
            AND: aluOut = opA & aluB;
            OR: aluOut = opA | aluB;
            XOR: aluOut = opA ^ aluB;
            SLLI: aluOut = opA << issueImm;
            default: aluOut = '0;
        endcase
    end

    // First step works on the freshly read operands
    assign stepAcc = mulActive ? mulAcc : '0;
    assign stepCand = mulActive ? mulCand : opA;
    assign stepPlier = mulActive ? mulPlier : opB;
    assign stepSum = stepAcc + partialProduct(stepCand, stepPlier[MUL_STEP_BITS-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            axLevel <= '0;
            mulActive <= 1'b0;
            mulCount <= '0;
            resultValid <= 1'b0;
        end else begin
            if (axLevelEn) begin
                axLevel <= axLevelData;
            end
            if (mulStart) begin
                mulActive <= 1'b1;
                mulCount <= MUL_COUNT_WIDTH'(MUL_CYCLES - 1);
                resultValid <= 1'b0;
            end else if (mulActive) begin
                mulCount <= mulCount - 1'b1;
                mulActive <= !mulLast;
                resultValid <= mulLast;
            end else begin
                resultValid <= issueValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mulStart) begin
            mulRd <= issueRd;
            mulLevel <= axLevel;
        end
        if (mulStart || mulActive) begin
            mulAcc <= stepSum;
            mulCand <= stepCand << MUL_STEP_BITS;
            mulPlier <= stepPlier >> MUL_STEP_BITS;
        end
        if (mulLast) begin
            resultReg <= mulRd;
            resultData <= truncateLow(stepSum, mulLevel);
        end else if (issueValid && !mulStart) begin
            resultReg <= issueRd;
            resultData <= aluTruncate ? truncateLow(aluOut, axLevel) : aluOut;
        end
    end

endmodule : ExecutionStage

/* hw/DecodeStage.sv */
// Decode stage
// Credit-fed instruction queue, format decode and issue to execution
`timescale 1ns/1ps

module DecodeStage (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    input  CoreTypes::InstWord instWord,
    input  logic execBusy,
    output logic creditReturn,
    output logic issueValid,
    output CoreTypes::OpCode issueOp,
    output CoreTypes::RegNumPath issueRd,
    output CoreTypes::RegNumPath issueRs1,
    output CoreTypes::RegNumPath issueRs2,
    output CoreTypes::RegNumPath issueImm,
    output logic issueUsesImm
);
    import CoreTypes::*;

    InstWord queueMem [INST_QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] writePtr;
    logic [QUEUE_PTR_WIDTH-1:0] readPtr;
    logic [QUEUE_PTR_WIDTH:0] count;
    InstWord head;
    logic pop;
    logic headIsR;
    logic headIsI;

    assign head = queueMem[readPtr];
    assign pop = (count != '0) && !execBusy;

    always_comb begin
        headIsR = 1'b0;
        headIsI = 1'b0;
        case (head.rType.opcode)
            ADD, SUB, AND, OR, XOR, MUL: headIsR = 1'b1;
            ADDI, SLLI: headIsI = 1'b1;
            // NOP and spare encodings are dropped
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            queueMem[writePtr] <= instWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
            creditReturn <= 1'b0;
            issueValid <= 1'b0;
        end else begin
            if (instValid) begin
                writePtr <= writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= readPtr + 1'b1;
            end
            if (instValid && !pop) begin
                count <= count + 1'b1;
            end else if (!instValid && pop) begin
                count <= count - 1'b1;
            end
            // Dropped entries still hand their credit back
            creditReturn <= pop;
            issueValid <= pop && (headIsR || headIsI);
        end
    end

    // Opcode, rd and rs1 sit in the same bits in both views
    always_ff @(posedge clk) begin
        if (pop) begin
            issueOp <= head.rType.opcode;
            issueRd <= head.rType.rd;
            issueRs1 <= head.rType.rs1;
            if (headIsI) begin
                issueRs2 <= '0;
                issueImm <= head.iType.imm;
                issueUsesImm <= 1'b1;
            end else begin
                issueRs2 <= head.rType.rs2;
                issueImm <= '0;
                issueUsesImm <= 1'b0;
            end
        end
    end

endmodule : DecodeStage

/* hw/RegisterFile.sv */
// Register file
// Sixteen data registers, two combinational reads and one write
`timescale 1ns/1ps

module RegisterFile (
    input  logic clk,
    input  logic rst,
    input  CoreTypes::RegNumPath readAddrA,
    input  CoreTypes::RegNumPath readAddrB,
    input  logic writeEnable,
    input  CoreTypes::RegNumPath writeAddr,
    input  CoreTypes::DataPath writeData,
    output CoreTypes::DataPath readDataA,
    output CoreTypes::DataPath readDataB
);
    import CoreTypes::*;

    DataPath regs [REG_NUM];

    // Register 0 is hardwired to zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule : RegisterFile

/* hw/CoreTypes.sv */
// Core slice shared definitions
// Opcodes, the two-view instruction word and the sizing constants
package CoreTypes;

    localparam int DATA_WIDTH = 16;
    localparam int REG_NUM = 16;
    localparam int REG_NUM_WIDTH = $clog2(REG_NUM);
    localparam int AX_LEVEL_WIDTH = 4;

    // Queue depth is also the sender's credit count after reset
    localparam int INST_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(INST_QUEUE_DEPTH);

    // Multiplier retires MUL_STEP_BITS multiplier bits per cycle
    localparam int MUL_CYCLES = 4;
    localparam int MUL_STEP_BITS = DATA_WIDTH / MUL_CYCLES;
    localparam int MUL_COUNT_WIDTH = $clog2(MUL_CYCLES);

    typedef logic [REG_NUM_WIDTH-1:0] RegNumPath;
    typedef logic [DATA_WIDTH-1:0] DataPath;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        MUL  = 4'h5,
        ADDI = 4'h6,
        SLLI = 4'h7,
        NOP  = 4'hF
    } OpCode;

    // Both views keep the opcode in the top nibble
    typedef union packed {
        struct packed {
            OpCode opcode;
            RegNumPath rd;
            RegNumPath rs1;
            RegNumPath rs2;
        } rType;
        struct packed {
            OpCode opcode;
            RegNumPath rd;
            RegNumPath rs1;
            logic [REG_NUM_WIDTH-1:0] imm;
        } iType;
    } InstWord;

endpackage
